// ==== hw/din_buffer_track.sv ====
/*
 * Input buffer tracker
 * Follows the fill level of the external input buffer from the commands
 * sent to it, and remembers when the closing byte of a stream went in.
 * Status changes on the edge that ends each command cycle
 */
`timescale 1ns/10ps
`include "subterranean_params.svh"

module din_buffer_track (
    input  logic                          clk,
    input  logic                          arstn,
    input  subterranean_pkg::buf_cmd_t    buf_cmd,
    output subterranean_pkg::buf_status_t buf_status
);
    import subterranean_pkg::*;

    localparam logic [`SUB_FILL_W-1:0] block_bytes = `SUB_BLOCK_BYTES;
    localparam logic [`SUB_FILL_W-1:0] one_byte    = 1;

    logic [`SUB_FILL_W-1:0] fill;
    logic                   last_loaded;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            fill        <= '0;
            last_loaded <= 1'b0;
        end else if (buf_cmd.clear) begin
            fill        <= '0;
            last_loaded <= 1'b0;
        end else if (buf_cmd.load) begin
            // Saturate at one block
            if (fill != block_bytes) begin
                fill <= fill + 1'b1;
            end
            // Closing byte stays flagged until the next clear
            if (buf_cmd.drain) begin
                last_loaded <= 1'b1;
            end
        end else if (buf_cmd.drain) begin
            fill <= '0;
        end
    end

    assign buf_status.empty = (fill == '0);
    assign buf_status.one   = (fill == one_byte);
    assign buf_status.full  = (fill == block_bytes);
    assign buf_status.last  = last_loaded;

endmodule

// ==== hw/round_counter.sv ====
/*
 * Round counter
 * Down counter loaded with the blank round count or the hash output
 * block count. Flags the final round while one remains
 */
`timescale 1ns/10ps
`include "subterranean_params.svh"

module round_counter (
    input  logic                      clk,
    input  logic                      arstn,
    input  subterranean_pkg::ctr_op_e ctr_op,
    output logic                      ctr_last
);
    import subterranean_pkg::*;

    localparam logic [`SUB_CTR_W-1:0] blank_rounds = `SUB_BLANK_ROUNDS;
    localparam logic [`SUB_CTR_W-1:0] hash_blocks  = `SUB_HASH_BLOCKS;
    localparam logic [`SUB_CTR_W-1:0] final_count  = 1;

    logic [`SUB_CTR_W-1:0] count;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            count <= '0;
        end else begin
            case (ctr_op)
                ctr_load_blank: count <= blank_rounds;
                ctr_load_out:   count <= hash_blocks;
                ctr_count: begin
                    // Hold at zero
                    if (count != '0) begin
                        count <= count - 1'b1;
                    end
                end
                default: count <= count;
            endcase
        end
    end

    assign ctr_last = (count == final_count);

endmodule

// ==== hw/sponge_ctrl_fsm.sv ====
/*
 * Sponge sequencing FSM
 * Takes instructions, paces the input and output streams and issues
 * absorb, buffer and counter commands for key loading and hashing.
 * Outputs are registered from the next phase so a phase and its
 * commands change on the same edge
 */
`timescale 1ns/10ps

module sponge_ctrl_fsm (
    input  logic                          clk,
    input  logic                          arstn,
    input  subterranean_pkg::inst_e       inst,
    input  logic                          inst_valid,
    output logic                          inst_ready,
    input  logic                          din_valid,
    input  logic                          din_last,
    output logic                          din_ready,
    input  logic                          dout_ready,
    output logic                          dout_valid,
    input  subterranean_pkg::buf_status_t buf_status,
    input  logic                          ctr_last,
    output subterranean_pkg::buf_cmd_t    buf_cmd,
    output subterranean_pkg::ctr_op_e     ctr_op,
    output subterranean_pkg::perm_cmd_t   perm_cmd
);
    import subterranean_pkg::*;

    typedef enum logic [3:0] {
        ph_reset,
        ph_idle,
        ph_key_stream,
        ph_key_last,
        ph_key_null,
        ph_hash_store,
        ph_hash_byte,
        ph_hash_null,
        ph_hash_pad,
        ph_hash_blank,
        ph_hash_out
    } phase_e;

    localparam perm_cmd_t perm_init_cmd = '{enable: 1'b0, init: 1'b1, absorb: 1'b0, sel: sel_none};

    phase_e    phase;
    phase_e    next_phase;
    logic      out_of_reset;
    logic      inst_xfer;
    logic      din_xfer;
    logic      dout_xfer;
    logic      inst_ready_next;
    logic      din_ready_next;
    logic      dout_valid_next;
    logic      clear_q;
    logic      clear_next;
    logic      drain_q;
    logic      drain_next;
    ctr_op_e   ctr_op_next;
    perm_cmd_t perm_cmd_next;

    function automatic perm_cmd_t absorb_cmd(din_sel_e sel);
        perm_cmd_t cmd;
        cmd        = '0;
        cmd.enable = 1'b1;
        cmd.absorb = 1'b1;
        cmd.sel    = sel;
        return cmd;
    endfunction

    assign inst_xfer = inst_valid & inst_ready;
    assign din_xfer  = din_valid & din_ready;
    assign dout_xfer = dout_valid & dout_ready;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            phase        <= ph_reset;
            out_of_reset <= 1'b0;
            inst_ready   <= 1'b0;
            din_ready    <= 1'b0;
            dout_valid   <= 1'b0;
            clear_q      <= 1'b1;
            drain_q      <= 1'b0;
            ctr_op       <= ctr_hold;
            perm_cmd     <= perm_init_cmd;
        end else begin
            phase        <= next_phase;
            out_of_reset <= 1'b1;
            inst_ready   <= inst_ready_next;
            din_ready    <= din_ready_next;
            dout_valid   <= dout_valid_next;
            clear_q      <= clear_next;
            drain_q      <= drain_next;
            ctr_op       <= ctr_op_next;
            perm_cmd     <= perm_cmd_next;
        end
    end

    always_comb begin
        next_phase = phase;
        case (phase)
            // Held one extra cycle after arstn is released
            ph_reset: begin
                if (out_of_reset) begin
                    next_phase = ph_idle;
                end
            end
            ph_idle: begin
                if (inst_xfer) begin
                    case (inst)
                        inst_key:  next_phase = ph_key_stream;
                        inst_hash: next_phase = ph_hash_store;
                        default:   next_phase = ph_reset;
                    endcase
                end
            end
            // Status is checked in the gap cycle after each byte
            ph_key_stream: begin
                if (buf_status.full || buf_status.last) begin
                    next_phase = ph_key_last;
                end
            end
            ph_key_last: begin
                if (!buf_status.last) begin
                    next_phase = ph_key_stream;
                end else if (buf_status.full) begin
                    next_phase = ph_key_null;
                end else begin
                    next_phase = ph_idle;
                end
            end
            ph_key_null:   next_phase = ph_idle;
            ph_hash_store: begin
                if (din_xfer) begin
                    next_phase = ph_hash_byte;
                end
            end
            ph_hash_byte:  next_phase = ph_hash_null;
            ph_hash_null:  next_phase = buf_status.last ? ph_hash_pad : ph_hash_store;
            ph_hash_pad:   next_phase = ph_hash_blank;
            ph_hash_blank: begin
                if (ctr_last) begin
                    next_phase = ph_hash_out;
                end
            end
            ph_hash_out: begin
                if (dout_xfer && ctr_last) begin
                    next_phase = ph_reset;
                end
            end
            default: next_phase = ph_reset;
        endcase
    end

    always_comb begin
        inst_ready_next = 1'b0;
        din_ready_next  = 1'b0;
        dout_valid_next = 1'b0;
        clear_next      = 1'b0;
        drain_next      = 1'b0;
        ctr_op_next     = ctr_hold;
        perm_cmd_next   = '0;
        case (next_phase)
            ph_reset: begin
                clear_next    = 1'b1;
                perm_cmd_next = perm_init_cmd;
            end
            ph_idle: begin
                inst_ready_next = 1'b1;
                clear_next      = 1'b1;
            end
            ph_key_stream: begin
                perm_cmd_next.enable = 1'b1;
                // One idle cycle after each byte lets the fill level settle
                din_ready_next = !din_xfer;
            end
            ph_key_last: begin
                perm_cmd_next = absorb_cmd(sel_block);
                drain_next    = 1'b1;
            end
            ph_key_null: perm_cmd_next = absorb_cmd(sel_null);
            ph_hash_store: begin
                perm_cmd_next.enable = 1'b1;
                din_ready_next       = 1'b1;
            end
            ph_hash_byte: begin
                perm_cmd_next = absorb_cmd(sel_byte);
                drain_next    = 1'b1;
            end
            ph_hash_null: perm_cmd_next = absorb_cmd(sel_null);
            ph_hash_pad: begin
                perm_cmd_next = absorb_cmd(sel_null);
                ctr_op_next   = ctr_load_blank;
            end
            ph_hash_blank: begin
                perm_cmd_next = absorb_cmd(sel_null);
                ctr_op_next   = ctr_count;
            end
            ph_hash_out: begin
                perm_cmd_next.enable = 1'b1;
                // First cycle loads the block count, each transfer is followed by a gap
                if (phase != ph_hash_out) begin
                    ctr_op_next = ctr_load_out;
                end else if (dout_xfer) begin
                    ctr_op_next = ctr_count;
                end else begin
                    dout_valid_next = 1'b1;
                end
            end
            default: perm_cmd_next = '0;
        endcase
    end

    // Load is the acceptance strobe itself
    assign buf_cmd.clear = clear_q;
    assign buf_cmd.load  = din_xfer;
    assign buf_cmd.drain = drain_q | (din_xfer & din_last);

endmodule

// ==== hw/subterranean_ctrl.sv ====
/*
 * Subterranean sequencing controller
 * Connects the sponge FSM to the input buffer tracker and the round
 * counter. Permutation and buffer commands leave for the external core
 */
`timescale 1ns/10ps

module subterranean_ctrl (
    input  logic                        clk,
    input  logic                        arstn,
    input  subterranean_pkg::inst_e     inst,
    input  logic                        inst_valid,
    output logic                        inst_ready,
    input  logic                        din_valid,
    input  logic                        din_last,
    output logic                        din_ready,
    input  logic                        dout_ready,
    output logic                        dout_valid,
    output subterranean_pkg::perm_cmd_t perm_cmd,
    output subterranean_pkg::buf_cmd_t  buf_cmd
);
    import subterranean_pkg::*;

    buf_status_t buf_status;
    ctr_op_e     ctr_op;
    logic        ctr_last;

    sponge_ctrl_fsm fsm_i (
        .clk        (clk),
        .arstn      (arstn),
        .inst       (inst),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .din_valid  (din_valid),
        .din_last   (din_last),
        .din_ready  (din_ready),
        .dout_ready (dout_ready),
        .dout_valid (dout_valid),
        .buf_status (buf_status),
        .ctr_last   (ctr_last),
        .buf_cmd    (buf_cmd),
        .ctr_op     (ctr_op),
        .perm_cmd   (perm_cmd)
    );

    din_buffer_track buf_i (
        .clk        (clk),
        .arstn      (arstn),
        .buf_cmd    (buf_cmd),
        .buf_status (buf_status)
    );

    round_counter ctr_i (
        .clk      (clk),
        .arstn    (arstn),
        .ctr_op   (ctr_op),
        .ctr_last (ctr_last)
    );

endmodule

// ==== hw/subterranean_params.svh ====
/*
 * Subterranean controller parameters
 * Widths, key block size and the round and output block counts used by
 * the sequencing controller
 */
`ifndef SUBTERRANEAN_PARAMS_SVH
`define SUBTERRANEAN_PARAMS_SVH

// Instruction bus width
`define SUB_INST_W 4

// Key bytes gathered before one block absorb
`define SUB_BLOCK_BYTES 4

// Buffer fill level, must hold SUB_BLOCK_BYTES
`define SUB_FILL_W 3

// Blank permutations between padding and squeezing
`define SUB_BLANK_ROUNDS 8

// Hash output blocks per digest
`define SUB_HASH_BLOCKS 8

// Round counter width
`define SUB_CTR_W 4

`endif

// ==== hw/subterranean_pkg.sv ====
/*
 * Subterranean controller types
 * Instruction codes, absorb selects, counter operations and the command
 * and status words passed between the controller blocks
 */
`include "subterranean_params.svh"

package subterranean_pkg;

    // Any code not listed here is treated as an unknown instruction
    typedef enum logic [`SUB_INST_W-1:0] {
        inst_key  = 4'b0100,
        inst_hash = 4'b1000
    } inst_e;

    // What the permutation core takes in on an absorb
    typedef enum logic [1:0] {
        sel_none  = 2'b00,
        sel_byte  = 2'b01,
        sel_null  = 2'b10,
        sel_block = 2'b11
    } din_sel_e;

    typedef enum logic [1:0] {
        ctr_hold       = 2'b00,
        ctr_load_blank = 2'b01,
        ctr_load_out   = 2'b10,
        ctr_count      = 2'b11
    } ctr_op_e;

    typedef struct packed {
        logic     enable;
        logic     init;
        logic     absorb;
        din_sel_e sel;
    } perm_cmd_t;

    // Load together with drain marks the closing byte of a stream
    typedef struct packed {
        logic clear;
        logic load;
        logic drain;
    } buf_cmd_t;

    typedef struct packed {
        logic empty;
        logic one;
        logic full;
        logic last;
    } buf_status_t;

endpackage

// ==== sim.f ====
+incdir+hw
hw/subterranean_pkg.sv
hw/din_buffer_track.sv
hw/round_counter.sv
hw/sponge_ctrl_fsm.sv
hw/subterranean_ctrl.sv
tests/subterranean_ctrl_chk.sv
tests/subterranean_ctrl_tb.sv

// ==== tests/subterranean_ctrl_chk.sv ====
/*
 * Controller protocol checker
 * Concurrent assertions on the stream handshakes, absorb selects and
 * reset values, bound into the controller top level
 */
`timescale 1ns/10ps

module subterranean_ctrl_chk (
    input logic                        clk,
    input logic                        arstn,
    input logic                        inst_ready,
    input logic                        din_ready,
    input logic                        dout_valid,
    input logic                        dout_ready,
    input subterranean_pkg::perm_cmd_t perm_cmd,
    input subterranean_pkg::buf_cmd_t  buf_cmd
);
    import subterranean_pkg::*;

    localparam perm_cmd_t reset_cmd = '{
        enable: 1'b0, init: 1'b1, absorb: 1'b0, sel: sel_none
    };
    localparam buf_cmd_t clear_cmd = '{clear: 1'b1, load: 1'b0, drain: 1'b0};

    // Bytes are only taken after an instruction was accepted
    no_din_in_idle: assert property (
        @(posedge clk) disable iff (!arstn) !(inst_ready && din_ready)
    ) else $error("din_ready is high while inst_ready is high");

    dout_valid_held: assert property (
        @(posedge clk) disable iff (!arstn) (dout_valid && !dout_ready) |=> dout_valid
    ) else $error("dout_valid dropped before the block was accepted");

    absorb_has_sel: assert property (
        @(posedge clk) disable iff (!arstn) !(perm_cmd.absorb && perm_cmd.sel == sel_none)
    ) else $error("perm_cmd absorbs with sel_none");

    // Second reset edge onward, flops may start unknown
    reset_outputs: assert property (
        @(posedge clk) (!arstn ##1 !arstn) |->
            (!inst_ready && !din_ready && !dout_valid &&
             perm_cmd == reset_cmd && buf_cmd == clear_cmd)
    ) else $error("outputs are not inactive during reset");

endmodule

bind subterranean_ctrl subterranean_ctrl_chk chk_i (
    .clk        (clk),
    .arstn      (arstn),
    .inst_ready (inst_ready),
    .din_ready  (din_ready),
    .dout_valid (dout_valid),
    .dout_ready (dout_ready),
    .perm_cmd   (perm_cmd),
    .buf_cmd    (buf_cmd)
);

// ==== tests/subterranean_ctrl_tb.sv ====
/*
 * Testbench for the Subterranean sequencing controller
 * Replays instruction vectors from a file, feeds key and message bytes
 * with random gaps, squeezes hash blocks under random back-pressure and
 * compares the strobe counts seen at the ports with the expected counts
 */
`timescale 1ns/10ps
`include "subterranean_params.svh"

module subterranean_ctrl_tb;
    import subterranean_pkg::*;

    localparam int max_tests  = 32;
    localparam int vec_fields = 6;

    localparam perm_cmd_t reset_cmd = '{
        enable: 1'b0, init: 1'b1, absorb: 1'b0, sel: sel_none
    };

    logic      clk;
    logic      arstn;
    inst_e     inst;
    logic      inst_valid;
    logic      inst_ready;
    logic      din_valid;
    logic      din_last;
    logic      din_ready;
    logic      dout_ready;
    logic      dout_valid;
    perm_cmd_t perm_cmd;
    buf_cmd_t  buf_cmd;

    // Six hex fields per test as laid out in the vector file
    logic [7:0] vec_mem [0:max_tests*vec_fields-1];
    integer     seed;
    int         num_tests;
    int         limit_cycles;
    logic       vectors_loaded = 1'b0;
    int         value_errors = 0;
    int         other_errors = 0;

    // Running strobe totals at the top-level ports
    int       n_byte = 0;
    int       n_null = 0;
    int       n_block = 0;
    int       n_absorb = 0;
    int       n_din = 0;
    int       n_din_ready = 0;
    int       n_load = 0;
    int       n_dout = 0;
    din_sel_e last_sel = sel_none;

    subterranean_ctrl dut_i (
        .clk        (clk),
        .arstn      (arstn),
        .inst       (inst),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .din_valid  (din_valid),
        .din_last   (din_last),
        .din_ready  (din_ready),
        .dout_ready (dout_ready),
        .dout_valid (dout_valid),
        .perm_cmd   (perm_cmd),
        .buf_cmd    (buf_cmd)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Values seen here are the ones the DUT registers on this edge
    always @(posedge clk) begin
        if (arstn) begin
            if (perm_cmd.absorb) begin
                n_absorb = n_absorb + 1;
                last_sel = perm_cmd.sel;
                case (perm_cmd.sel)
                    sel_byte:  n_byte = n_byte + 1;
                    sel_null:  n_null = n_null + 1;
                    sel_block: n_block = n_block + 1;
                    default: ;
                endcase
            end
            if (din_valid && din_ready) n_din = n_din + 1;
            if (din_ready) n_din_ready = n_din_ready + 1;
            if (buf_cmd.load) n_load = n_load + 1;
            if (dout_valid && dout_ready) n_dout = n_dout + 1;
        end
    end

    task automatic check_count(input string name, input int got, input int expected);
        if (got !== expected) begin
            $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, expected);
            value_errors = value_errors + 1;
        end
    endtask

    task automatic check_sel(input string name, input din_sel_e got, input din_sel_e expected);
        if (got !== expected) begin
            $display("Fail at %0t: %s got %s expected %s", $time, name, got.name(),
                     expected.name());
            value_errors = value_errors + 1;
        end
    endtask

    task automatic check_cmd(input string name, input perm_cmd_t got,
                             input perm_cmd_t expected);
        if (got !== expected) begin
            $display("Fail at %0t: %s got %b expected %b", $time, name, got, expected);
            value_errors = value_errors + 1;
        end
    endtask

    // Key ends on a block absorb for a partial block and on a null absorb otherwise
    function automatic din_sel_e expected_last_sel(input logic [7:0] code, input int len);
        din_sel_e sel;
        if (code == inst_key) begin
            sel = (len % `SUB_BLOCK_BYTES == 0) ? sel_null : sel_block;
        end else if (code == inst_hash) begin
            sel = sel_null;
        end else begin
            sel = sel_none;
        end
        return sel;
    endfunction

    task automatic send_instruction(input logic [7:0] code);
        @(posedge clk);
        inst       <= inst_e'(code[3:0]);
        inst_valid <= 1'b1;
        do @(negedge clk); while (!inst_ready);
        @(posedge clk);
        inst_valid <= 1'b0;
    endtask

    // Valid is held once raised and bytes follow gaps of zero to three cycles
    task automatic send_bytes(input int len);
        int gap;
        for (int i = 0; i < len; i++) begin
            gap = $random(seed) & 3;
            repeat (gap) @(posedge clk);
            @(posedge clk);
            din_valid <= 1'b1;
            din_last  <= (i == len - 1);
            do @(negedge clk); while (!din_ready);
            @(posedge clk);
            din_valid <= 1'b0;
            din_last  <= 1'b0;
        end
    endtask

    // A spare byte stays on offer until the instruction ends and must not be taken
    task automatic wait_done();
        logic done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (inst_ready) begin
                done = 1'b1;
            end else begin
                @(posedge clk);
                din_valid  <= 1'b1;
                dout_ready <= $random(seed) & 1;
            end
        end
        @(posedge clk);
        din_valid  <= 1'b0;
        dout_ready <= 1'b0;
    endtask

    task automatic run_vector(input int t);
        logic [7:0] code;
        int         len;
        int         base_byte;
        int         base_null;
        int         base_block;
        int         base_absorb;
        int         base_din;
        int         base_ready;
        int         base_load;
        int         base_dout;
        din_sel_e   seen_sel;
        code = vec_mem[t*vec_fields];
        len  = vec_mem[t*vec_fields+1];
        do @(negedge clk); while (!inst_ready);
        base_byte   = n_byte;
        base_null   = n_null;
        base_block  = n_block;
        base_absorb = n_absorb;
        base_din    = n_din;
        base_ready  = n_din_ready;
        base_load   = n_load;
        base_dout   = n_dout;
        send_instruction(code);
        send_bytes(len);
        wait_done();
        @(negedge clk);
        check_count("din transfers", n_din - base_din, len);
        check_count("buf_cmd loads", n_load - base_load, len);
        check_count("perm_cmd byte absorbs", n_byte - base_byte, vec_mem[t*vec_fields+2]);
        check_count("perm_cmd null absorbs", n_null - base_null, vec_mem[t*vec_fields+3]);
        check_count("perm_cmd block absorbs", n_block - base_block, vec_mem[t*vec_fields+4]);
        check_count("dout transfers", n_dout - base_dout, vec_mem[t*vec_fields+5]);
        if (len == 0) begin
            check_count("din_ready cycles", n_din_ready - base_ready, 0);
        end
        seen_sel = (n_absorb == base_absorb) ? sel_none : last_sel;
        check_sel("perm_cmd.sel of last absorb", seen_sel, expected_last_sel(code, len));
    endtask

    // Watchdog allows (length + 40) x 8 cycles per test plus reset
    initial begin
        wait (vectors_loaded === 1'b1);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", limit_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int sum_len;
        int edges;
        seed       = 32'hb153c270;
        arstn      = 1'b0;
        inst       = inst_e'(4'h0);
        inst_valid = 1'b0;
        din_valid  = 1'b0;
        din_last   = 1'b0;
        dout_ready = 1'b0;
        $readmemh("tests/subterranean_ctrl_vectors.txt", vec_mem);
        num_tests = 0;
        sum_len   = 0;
        while (num_tests < max_tests && !$isunknown(vec_mem[num_tests*vec_fields])) begin
            sum_len   = sum_len + vec_mem[num_tests*vec_fields+1];
            num_tests = num_tests + 1;
        end
        limit_cycles   = 8 * (sum_len + 40 * num_tests) + 64;
        vectors_loaded = 1'b1;
        if (num_tests == 0) begin
            $display("No test vectors could be read from the vector file");
            other_errors = other_errors + 1;
        end

        // Reset held for 16 rising edges
        repeat (15) @(posedge clk);
        @(negedge clk);
        check_count("inst_ready", inst_ready, 0);
        check_count("din_ready", din_ready, 0);
        check_count("dout_valid", dout_valid, 0);
        check_cmd("perm_cmd", perm_cmd, reset_cmd);
        @(posedge clk);
        arstn <= 1'b1;

        edges = 0;
        do begin
            @(posedge clk);
            edges = edges + 1;
            @(negedge clk);
            if (!inst_ready) begin
                check_cmd("perm_cmd", perm_cmd, reset_cmd);
                check_count("din_ready", din_ready, 0);
                check_count("dout_valid", dout_valid, 0);
            end
        end while (!inst_ready && edges < 4);
        check_count("inst_ready rising edge", edges, 2);

        for (int t = 0; t < num_tests; t++) begin
            run_vector(t);
        end

        $display("Errors: %0d value mismatches, %0d other failures", value_errors,
                 other_errors);
        if (value_errors + other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== tests/subterranean_ctrl_vectors.txt ====
// Columns in hex: instruction code, byte length, expected byte absorbs,
// null absorbs, block absorbs and dout transfers
4 01 00 00 01 00
4 03 00 00 01 00
4 04 00 01 01 00
4 07 00 00 02 00
4 08 00 01 02 00
4 0c 00 01 03 00
8 01 01 0a 00 08
8 02 02 0b 00 08
3 00 00 00 00 00
8 05 05 0e 00 08
4 09 00 00 03 00
8 10 10 19 00 08
f 00 00 00 00 00
8 03 03 0c 00 08
